//--- Bender.yml
package:
  name: dcache

sources:
  - src/dcache_pkg.sv
  - src/dcache_tag_store.sv
  - src/dcache_data_ways.sv
  - src/dcache_ctrl.sv
  - src/dcache_inval_regs.sv
  - src/dcache_top.sv
  - target: test
    files:
      - verif/dcache_sva.sv
      - verif/tb_dcache.sv

//--- build.f
src/dcache_pkg.sv
src/dcache_tag_store.sv
src/dcache_data_ways.sv
src/dcache_ctrl.sv
src/dcache_inval_regs.sv
src/dcache_top.sv
verif/dcache_sva.sv
verif/tb_dcache.sv

//--- src/dcache_ctrl.sv
// Cache FSM for lookup, refill word counting, victim latch and invalidate
`default_nettype none

module dcache_ctrl (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              cpu_req_i,
  input  logic                              cpu_we_i,
  input  logic [dcache_pkg::ADDR_W-1:0]     cpu_adr_i,
  input  logic                              refill_we_i,
  input  logic [dcache_pkg::NUM_WAYS-1:0]   way_hit_i,
  input  logic                              lru_way_i,
  input  logic                              inval_req_i,
  output logic                              cpu_ack_o,
  output logic                              refill_req_o,
  output logic [dcache_pkg::ADDR_W-1:0]     refill_adr_o,
  output logic                              refill_done_o,
  output logic [1:0]                        tag_op_o,
  output logic                              victim_o,
  output logic [dcache_pkg::WORD_W-1:0]     refill_word_o,
  output logic                              wr_hit_o,
  output logic                              inval_done_o
);
  import dcache_pkg::*;

  dcache_addr_u adr;

  logic [1:0]        state_q;
  logic [1:0]        state_d;
  logic [WORD_W-1:0] word_cnt_q;
  logic              victim_q;

  logic hit;
  logic in_lookup;
  logic in_refill;
  logic rd_miss;
  logic last_word;

  assign adr       = cpu_adr_i;
  assign hit       = |way_hit_i;
  assign in_lookup = (state_q == ST_LOOKUP);
  assign in_refill = (state_q == ST_REFILL);

  // Only reads allocate; a write miss just completes
  assign rd_miss   = in_lookup & ~cpu_we_i & ~hit;
  assign last_word = in_refill & refill_we_i & (word_cnt_q == WORD_W'(LINE_WORDS - 1));

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        // Invalidate wins over a waiting CPU request
        if (inval_req_i) begin
          state_d = ST_INVAL;
        end else if (cpu_req_i) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (rd_miss) begin
          state_d = ST_REFILL;
        end else begin
          state_d = ST_IDLE;
        end
      end
      ST_REFILL: begin
        // Back to IDLE, then the held request is looked up again
        if (last_word) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= ST_IDLE;
      word_cnt_q <= '0;
      victim_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // Victim comes from the LRU bit read out in LOOKUP
      if (rd_miss) begin
        victim_q   <= lru_way_i;
        word_cnt_q <= '0;
      end else if (in_refill && refill_we_i) begin
        word_cnt_q <= word_cnt_q + 1'b1;
      end
    end
  end

  // Tag store command for this cycle
  always_comb begin
    tag_op_o = TAG_OP_NONE;
    if (in_lookup && hit) begin
      tag_op_o = TAG_OP_TOUCH;
    end else if (last_word) begin
      tag_op_o = TAG_OP_INSTALL;
    end else if (state_q == ST_INVAL) begin
      tag_op_o = TAG_OP_CLEAR;
    end
  end

  // Hits and all writes finish in the LOOKUP cycle
  assign cpu_ack_o     = in_lookup & cpu_req_i & (hit | cpu_we_i);
  assign wr_hit_o      = in_lookup & cpu_we_i & hit;

  // Level request from the miss cycle to the last word
  assign refill_req_o  = rd_miss | in_refill;
  assign refill_adr_o  = {adr.line.line_num, {BYTE_OFF_W{1'b0}}};
  assign refill_done_o = last_word;
  assign refill_word_o = word_cnt_q;
  assign victim_o      = victim_q;

  // INVALIDATE lasts a single cycle
  assign inval_done_o  = (state_q == ST_INVAL);

endmodule

`default_nettype wire

//--- src/dcache_data_ways.sv
// Two way data RAMs with byte-merged write hits, refill writes and read mux
`default_nettype none

module dcache_data_ways (
  input  logic                                clk,
  input  logic [dcache_pkg::ADDR_W-1:0]       cpu_adr_i,
  input  logic [dcache_pkg::DATA_W-1:0]       cpu_dat_i,
  input  logic [dcache_pkg::DATA_W/8-1:0]     cpu_bsel_i,
  input  logic [dcache_pkg::NUM_WAYS-1:0]     way_hit_i,
  input  logic                                wr_hit_i,
  input  logic                                victim_i,
  input  logic                                refill_we_i,
  input  logic [dcache_pkg::WORD_W-1:0]       refill_word_i,
  input  logic [dcache_pkg::DATA_W-1:0]       refill_dat_i,
  output logic [dcache_pkg::DATA_W-1:0]       cpu_dat_o
);
  import dcache_pkg::*;

  dcache_addr_u adr;

  logic [SET_W+WORD_W-1:0] rd_addr;
  logic [SET_W+WORD_W-1:0] wr_addr;
  logic [DATA_W-1:0]       dout [NUM_WAYS];

  assign adr     = cpu_adr_i;
  assign rd_addr = {adr.lookup.set_idx, adr.lookup.word};

  // Refill words land in the set of the missing address
  assign wr_addr = refill_we_i ? {adr.lookup.set_idx, refill_word_i} : rd_addr;

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    logic [DATA_W-1:0] mem [RAM_DEPTH];
    logic [DATA_W-1:0] rd_q;
    logic [DATA_W-1:0] merged;
    logic [DATA_W-1:0] wr_dat;
    logic              wr_en;

    // Unselected bytes keep what the lookup read out
    always_comb begin
      for (int b = 0; b < DATA_W/8; b++) begin
        merged[8*b +: 8] = cpu_bsel_i[b] ? cpu_dat_i[8*b +: 8] : rd_q[8*b +: 8];
      end
    end

    // Write hit goes to the hitting way, refill to the victim
    assign wr_en  = (wr_hit_i & way_hit_i[w]) | (refill_we_i & (victim_i == 1'(w)));
    assign wr_dat = refill_we_i ? refill_dat_i : merged;

    always_ff @(posedge clk) begin
      if (wr_en) begin
        mem[wr_addr] <= wr_dat;
      end
      rd_q <= mem[rd_addr];
    end

    assign dout[w] = rd_q;
  end

  // Only meaningful on a hit
  assign cpu_dat_o = way_hit_i[1] ? dout[1] : dout[0];

endmodule

`default_nettype wire

//--- src/dcache_inval_regs.sv
// SPR register block decoding block flush/invalidate writes, pending set and ack
`default_nettype none

module dcache_inval_regs (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              spr_bus_stb_i,
  input  logic                              spr_bus_we_i,
  input  logic [15:0]                       spr_bus_addr_i,
  input  logic [dcache_pkg::DATA_W-1:0]     spr_bus_dat_i,
  input  logic                              inval_done_i,
  output logic                              inval_req_o,
  output logic [dcache_pkg::SET_W-1:0]      inval_set_o,
  output logic                              spr_bus_ack_o
);
  import dcache_pkg::*;

  logic accept;
  logic is_inval;

  // New access only when nothing is pending or being acknowledged
  assign accept   = spr_bus_stb_i & ~spr_bus_ack_o & ~inval_req_o;
  // Flush and invalidate behave the same
  assign is_inval = spr_bus_we_i &
                    ((spr_bus_addr_i == SPR_DCBFR_ADDR) | (spr_bus_addr_i == SPR_DCBIR_ADDR));

  always_ff @(posedge clk) begin
    if (rst) begin
      inval_req_o   <= 1'b0;
      spr_bus_ack_o <= 1'b0;
    end else begin
      if (accept && is_inval) begin
        inval_req_o <= 1'b1;
      end else if (inval_done_i) begin
        inval_req_o <= 1'b0;
      end
      // Other accesses ack right away, invalidates once the set is cleared
      spr_bus_ack_o <= (accept & ~is_inval) | inval_done_i;
    end
  end

  // Set field of the written effective address
  always_ff @(posedge clk) begin
    if (accept && is_inval) begin
      inval_set_o <= spr_bus_dat_i[BYTE_OFF_W +: SET_W];
    end
  end

endmodule

`default_nettype wire

//--- src/dcache_pkg.sv
// Cache geometry, SPR addresses, FSM and tag-operation codes, address union
`default_nettype none

package dcache_pkg;

  // Word and address widths of the core
  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 32;

  // 16-byte lines, 4 words each
  localparam int BYTE_OFF_W = 4;
  localparam int WORD_W     = 2;
  localparam int LINE_WORDS = 4;

  // 16 sets, two ways, tag is what is left above the set index
  localparam int SET_W      = 4;
  localparam int NUM_SETS   = 16;
  localparam int TAG_W      = 24;
  localparam int NUM_WAYS   = 2;

  // Words per way RAM, one line per set
  localparam int RAM_DEPTH  = NUM_SETS * LINE_WORDS;

  // SPR group 3 block flush and block invalidate
  localparam logic [15:0] SPR_DCBFR_ADDR = 16'h1802;
  localparam logic [15:0] SPR_DCBIR_ADDR = 16'h1803;

  // What the tag store writes this cycle
  localparam logic [1:0] TAG_OP_NONE    = 2'd0;
  localparam logic [1:0] TAG_OP_TOUCH   = 2'd1;
  localparam logic [1:0] TAG_OP_INSTALL = 2'd2;
  localparam logic [1:0] TAG_OP_CLEAR   = 2'd3;

  // Controller states
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_LOOKUP = 2'd1;
  localparam logic [1:0] ST_REFILL = 2'd2;
  localparam logic [1:0] ST_INVAL  = 2'd3;

  // One CPU address, seen either as lookup fields or as a line number
  typedef union packed {
    struct packed {
      logic [TAG_W-1:0]               tag;
      logic [SET_W-1:0]               set_idx;
      logic [WORD_W-1:0]              word;
      logic [BYTE_OFF_W-WORD_W-1:0]   byte_off;
    } lookup;
    struct packed {
      logic [ADDR_W-BYTE_OFF_W-1:0]   line_num;
      logic [BYTE_OFF_W-1:0]          offset;
    } line;
  } dcache_addr_u;

endpackage

`default_nettype wire

//--- src/dcache_tag_store.sv
// Tag, valid and LRU array with registered read, way-hit compare and tag writes
`default_nettype none

module dcache_tag_store (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [dcache_pkg::ADDR_W-1:0]     cpu_adr_i,
  input  logic [1:0]                        tag_op_i,
  input  logic                              victim_i,
  input  logic [dcache_pkg::SET_W-1:0]      inval_set_i,
  output logic [dcache_pkg::NUM_WAYS-1:0]   way_hit_o,
  output logic                              lru_way_o
);
  import dcache_pkg::*;

  dcache_addr_u adr;

  // Per-set state; LRU bit names the way to replace next
  logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
  logic [TAG_W-1:0]    tag_q   [NUM_WAYS][NUM_SETS];
  logic                lru_q   [NUM_SETS];

  // Read port registers, one cycle behind the address
  logic [NUM_WAYS-1:0] rd_valid_q;
  logic [TAG_W-1:0]    rd_tag_q [NUM_WAYS];
  logic                rd_lru_q;

  assign adr = cpu_adr_i;

  // Array writes
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
        lru_q[s]   <= 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
          tag_q[w][s] <= '0;
        end
      end
    end else begin
      case (tag_op_i)
        TAG_OP_TOUCH: begin
          // Way 0 hit makes way 1 the LRU, and the other way round
          lru_q[adr.lookup.set_idx] <= way_hit_o[0];
        end
        TAG_OP_INSTALL: begin
          valid_q[adr.lookup.set_idx][victim_i] <= 1'b1;
          tag_q[victim_i][adr.lookup.set_idx]   <= adr.lookup.tag;
          // Freshly filled way is the most recent one
          lru_q[adr.lookup.set_idx]             <= ~victim_i;
        end
        TAG_OP_CLEAR: begin
          valid_q[inval_set_i] <= '0;
          lru_q[inval_set_i]   <= 1'b0;
          for (int w = 0; w < NUM_WAYS; w++) begin
            tag_q[w][inval_set_i] <= '0;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Synchronous read at the set of the held address
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid_q <= '0;
    end else begin
      rd_valid_q <= valid_q[adr.lookup.set_idx];
    end
    rd_lru_q <= lru_q[adr.lookup.set_idx];
    for (int w = 0; w < NUM_WAYS; w++) begin
      rd_tag_q[w] <= tag_q[w][adr.lookup.set_idx];
    end
  end

  // Compare against the tag of the same, still held, address
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_cmp
    assign way_hit_o[w] = rd_valid_q[w] & (rd_tag_q[w] == adr.lookup.tag);
  end

  assign lru_way_o = rd_lru_q;

endmodule

`default_nettype wire

//--- src/dcache_top.sv
// Data cache top level wiring register block, controller, tag store and data ways
`default_nettype none

module dcache_top (
  input  logic                              clk,
  input  logic                              rst,
  // CPU request, held until ack
  input  logic                              cpu_req_i,
  input  logic                              cpu_we_i,
  input  logic [dcache_pkg::ADDR_W-1:0]     cpu_adr_i,
  input  logic [dcache_pkg::DATA_W-1:0]     cpu_dat_i,
  input  logic [dcache_pkg::DATA_W/8-1:0]   cpu_bsel_i,
  output logic                              cpu_ack_o,
  output logic [dcache_pkg::DATA_W-1:0]     cpu_dat_o,
  // Line refill from outside
  input  logic                              refill_we_i,
  input  logic [dcache_pkg::DATA_W-1:0]     refill_dat_i,
  output logic                              refill_req_o,
  output logic [dcache_pkg::ADDR_W-1:0]     refill_adr_o,
  output logic                              refill_done_o,
  // SPR bus
  input  logic                              spr_bus_stb_i,
  input  logic                              spr_bus_we_i,
  input  logic [15:0]                       spr_bus_addr_i,
  input  logic [dcache_pkg::DATA_W-1:0]     spr_bus_dat_i,
  output logic                              spr_bus_ack_o
);
  import dcache_pkg::*;

  logic [1:0]          tag_op;
  logic                victim;
  logic [WORD_W-1:0]   refill_word;
  logic                wr_hit;
  logic [NUM_WAYS-1:0] way_hit;
  logic                lru_way;
  logic                inval_req;
  logic [SET_W-1:0]    inval_set;
  logic                inval_done;

  dcache_inval_regs u_inval_regs (
    .clk            (clk),
    .rst            (rst),
    .spr_bus_stb_i  (spr_bus_stb_i),
    .spr_bus_we_i   (spr_bus_we_i),
    .spr_bus_addr_i (spr_bus_addr_i),
    .spr_bus_dat_i  (spr_bus_dat_i),
    .inval_done_i   (inval_done),
    .inval_req_o    (inval_req),
    .inval_set_o    (inval_set),
    .spr_bus_ack_o  (spr_bus_ack_o)
  );

  dcache_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .cpu_req_i     (cpu_req_i),
    .cpu_we_i      (cpu_we_i),
    .cpu_adr_i     (cpu_adr_i),
    .refill_we_i   (refill_we_i),
    .way_hit_i     (way_hit),
    .lru_way_i     (lru_way),
    .inval_req_i   (inval_req),
    .cpu_ack_o     (cpu_ack_o),
    .refill_req_o  (refill_req_o),
    .refill_adr_o  (refill_adr_o),
    .refill_done_o (refill_done_o),
    .tag_op_o      (tag_op),
    .victim_o      (victim),
    .refill_word_o (refill_word),
    .wr_hit_o      (wr_hit),
    .inval_done_o  (inval_done)
  );

  dcache_tag_store u_tag_store (
    .clk         (clk),
    .rst         (rst),
    .cpu_adr_i   (cpu_adr_i),
    .tag_op_i    (tag_op),
    .victim_i    (victim),
    .inval_set_i (inval_set),
    .way_hit_o   (way_hit),
    .lru_way_o   (lru_way)
  );

  // Refill strobes come straight from outside, only during REFILL
  dcache_data_ways u_data_ways (
    .clk           (clk),
    .cpu_adr_i     (cpu_adr_i),
    .cpu_dat_i     (cpu_dat_i),
    .cpu_bsel_i    (cpu_bsel_i),
    .way_hit_i     (way_hit),
    .wr_hit_i      (wr_hit),
    .victim_i      (victim),
    .refill_we_i   (refill_we_i),
    .refill_word_i (refill_word),
    .refill_dat_i  (refill_dat_i),
    .cpu_dat_o     (cpu_dat_o)
  );

endmodule

`default_nettype wire

//--- verif/dcache_sva.sv
// Protocol assertions for dcache_top and their bind
`default_nettype none

module dcache_sva (
  input logic clk,
  input logic rst,
  input logic cpu_ack_i,
  input logic refill_req_i,
  input logic refill_done_i,
  input logic spr_bus_ack_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failures seen so far, read by the testbench top
  int fail_cnt = 0;

  // Acks last one cycle
  a_cpu_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    cpu_ack_i |=> !cpu_ack_i)
    else begin
      fail_cnt++;
      $error("cpu_ack_o stayed high for more than one cycle");
    end

  a_spr_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    spr_bus_ack_i |=> !spr_bus_ack_i)
    else begin
      fail_cnt++;
      $error("spr_bus_ack_o stayed high for more than one cycle");
    end

  // Done only inside a refill
  a_done_in_refill: assert property (@(posedge clk) disable iff (rst)
    refill_done_i |-> refill_req_i)
    else begin
      fail_cnt++;
      $error("refill_done_o pulsed without refill_req_o");
    end

  a_reset_quiet: assert property (@(posedge clk)
    rst |=> !cpu_ack_i && !refill_req_i && !refill_done_i && !spr_bus_ack_i)
    else begin
      fail_cnt++;
      $error("control outputs not low after reset");
    end

endmodule

bind dcache_top dcache_sva u_sva (
  .clk           (clk),
  .rst           (rst),
  .cpu_ack_i     (cpu_ack_o),
  .refill_req_i  (refill_req_o),
  .refill_done_i (refill_done_o),
  .spr_bus_ack_i (spr_bus_ack_o)
);

`default_nettype wire

//--- verif/tb_dcache.sv
// Testbench for dcache_top with backing-memory model, refill responder and checking assertions
`default_nettype none

module tb_dcache;
  timeunit 1ns;
  timeprecision 100ps;
  import dcache_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int GAP_BITS   = 2;
  // Worst line refill: every word after the longest gap, plus lookup and retry
  localparam int REFILL_MAX = LINE_WORDS * ((1 << GAP_BITS) + 1) + 4;
  localparam int NUM_OPS    = 20;
  localparam int TIMEOUT_NS = (NUM_OPS * (REFILL_MAX + 6) + 10) * CLK_PERIOD;

  // Lines A, B, C share set 3; D sits in set 5
  localparam logic [31:0] ADR_A = 32'h0000_1230;
  localparam logic [31:0] ADR_B = 32'h0000_4530;
  localparam logic [31:0] ADR_C = 32'h0000_7830;
  localparam logic [31:0] ADR_D = 32'h0000_9a54;

  logic              clk;
  logic              rst;
  logic              cpu_req_i;
  logic              cpu_we_i;
  logic [ADDR_W-1:0] cpu_adr_i;
  logic [DATA_W-1:0] cpu_dat_i;
  logic [3:0]        cpu_bsel_i;
  logic              cpu_ack_o;
  logic [DATA_W-1:0] cpu_dat_o;
  logic              refill_we_i;
  logic [DATA_W-1:0] refill_dat_i;
  logic              refill_req_o;
  logic [ADDR_W-1:0] refill_adr_o;
  logic              refill_done_o;
  logic              spr_bus_stb_i;
  logic              spr_bus_we_i;
  logic [15:0]       spr_bus_addr_i;
  logic [DATA_W-1:0] spr_bus_dat_i;
  logic              spr_bus_ack_o;

  // Expectations of the access in flight
  logic              exp_miss;
  logic [DATA_W-1:0] exp_dat;
  logic [ADDR_W-1:0] exp_line;
  int                done_cnt;
  int                done_base;
  int                data_errs;
  int                proto_errs;
  logic [7:0]        lfsr_q;

  // Words written by the CPU, on top of the scrambled fill
  logic [31:0] overlay [logic [31:0]];

  dcache_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Fill pattern mixes every address bit
  function automatic logic [31:0] backing_word(input logic [31:0] a);
    logic [31:0] wa;
    wa = {a[31:2], 2'b00};
    if (overlay.exists(wa)) begin
      return overlay[wa];
    end
    return ((wa ^ 32'h5a5a_c3c3) * 32'h9e37_79b1) ^ (wa >> 7);
  endfunction

  // Taps 8, 6, 5, 4
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  // One LFSR step per bit of the gap
  task automatic draw_gap(output int gap);
    gap = 0;
    for (int i = 0; i < GAP_BITS; i++) begin
      gap    = (gap << 1) | int'(lfsr_q[7]);
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  task automatic cpu_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] bsel, input logic miss);
    logic [31:0] word;
    @(posedge clk);
    #1;
    exp_miss   = miss & ~we;
    exp_dat    = backing_word(adr);
    // 16-byte line holding the address
    exp_line   = adr & 32'hffff_fff0;
    done_base  = done_cnt;
    cpu_we_i   = we;
    cpu_adr_i  = adr;
    cpu_dat_i  = dat;
    cpu_bsel_i = bsel;
    cpu_req_i  = 1'b1;
    @(posedge clk);
    while (!cpu_ack_o) @(posedge clk);
    #1;
    cpu_req_i = 1'b0;
    // Outside memory follows every write, hit or miss
    if (we) begin
      word = backing_word(adr);
      for (int b = 0; b < 4; b++) begin
        if (bsel[b]) word[8*b +: 8] = dat[8*b +: 8];
      end
      overlay[{adr[31:2], 2'b00}] = word;
    end
  endtask

  task automatic read_word(input logic [31:0] adr, input logic miss);
    cpu_access(1'b0, adr, 32'h0, 4'hf, miss);
  endtask

  task automatic write_word(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] bsel);
    cpu_access(1'b1, adr, dat, bsel, 1'b0);
  endtask

  task automatic spr_write(input logic [15:0] addr, input logic [31:0] dat);
    @(posedge clk);
    #1;
    spr_bus_stb_i  = 1'b1;
    spr_bus_we_i   = 1'b1;
    spr_bus_addr_i = addr;
    spr_bus_dat_i  = dat;
    @(posedge clk);
    while (!spr_bus_ack_o) @(posedge clk);
    #1;
    spr_bus_stb_i = 1'b0;
  endtask

  // Refill responder, one line per request
  initial begin : refill_responder
    logic [31:0] line_adr;
    int          gap;
    forever begin
      @(posedge clk);
      if (!rst && refill_req_o) begin
        line_adr = refill_adr_o;
        #1;
        for (int w = 0; w < LINE_WORDS; w++) begin
          draw_gap(gap);
          repeat (gap) begin
            @(posedge clk);
            #1;
          end
          refill_we_i  = 1'b1;
          refill_dat_i = backing_word(line_adr + 32'(4 * w));
          @(posedge clk);
          #1;
          refill_we_i = 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (rst) done_cnt <= 0;
    else if (refill_done_o) done_cnt <= done_cnt + 1;
  end

  // Read data against the backing model
  a_rd_data: assert property (@(posedge clk) disable iff (rst)
    cpu_ack_o && !cpu_we_i |-> cpu_dat_o == exp_dat)
    else begin
      data_errs++;
      $display("error %0t ns: cpu_dat_o = %h, expected %h",
               $time, $sampled(cpu_dat_o), $sampled(exp_dat));
    end

  // Hit or write: ack one cycle after the request edge, no refill
  a_fast_ack: assert property (@(posedge clk) disable iff (rst)
    $rose(cpu_req_i) && (cpu_we_i || !exp_miss) |=> cpu_ack_o && !refill_req_o)
    else begin
      proto_errs++;
      $display("at %0t ns a hit or write was not acknowledged in the next cycle", $time);
    end

  a_miss_start: assert property (@(posedge clk) disable iff (rst)
    $rose(cpu_req_i) && !cpu_we_i && exp_miss |=> refill_req_o && !cpu_ack_o)
    else begin
      proto_errs++;
      $display("at %0t ns a read miss did not start a refill", $time);
    end

  a_refill_adr: assert property (@(posedge clk) disable iff (rst)
    refill_req_o |-> refill_adr_o == exp_line)
    else begin
      proto_errs++;
      $display("error %0t ns: refill_adr_o = %h, expected %h", $time,
               $sampled(refill_adr_o), $sampled(exp_line));
    end

  // One refill per miss, none for a hit or a write
  a_refill_count: assert property (@(posedge clk) disable iff (rst)
    cpu_ack_o |-> done_cnt == done_base + (exp_miss ? 1 : 0))
    else begin
      proto_errs++;
      $display("at %0t ns the access saw %0d refills", $time, $sampled(done_cnt) - done_base);
    end

  a_spr_other: assert property (@(posedge clk) disable iff (rst)
    $rose(spr_bus_stb_i) && spr_bus_addr_i != SPR_DCBIR_ADDR &&
    spr_bus_addr_i != SPR_DCBFR_ADDR |=> spr_bus_ack_o)
    else begin
      proto_errs++;
      $display("at %0t ns an unrelated SPR write was not acknowledged next cycle", $time);
    end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: cache operations did not complete within %0d ns", TIMEOUT_NS);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : stimulus
    int total;
    rst            = 1'b1;
    cpu_req_i      = 1'b0;
    cpu_we_i       = 1'b0;
    cpu_adr_i      = '0;
    cpu_dat_i      = '0;
    cpu_bsel_i     = '0;
    refill_we_i    = 1'b0;
    refill_dat_i   = '0;
    spr_bus_stb_i  = 1'b0;
    spr_bus_we_i   = 1'b0;
    spr_bus_addr_i = '0;
    spr_bus_dat_i  = '0;
    exp_miss       = 1'b0;
    exp_dat        = '0;
    exp_line       = '0;
    done_base      = 0;
    data_errs      = 0;
    proto_errs     = 0;
    lfsr_q         = 8'd33;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // Cold miss, then hits in the same line
    read_word(ADR_A + 32'd4, 1'b1);
    read_word(ADR_A + 32'd4, 1'b0);
    read_word(ADR_A + 32'd8, 1'b0);
    // Middle two bytes only
    write_word(ADR_A + 32'd4, 32'hdead_beef, 4'b0110);
    read_word(ADR_A + 32'd4, 1'b0);
    // No allocate on write miss
    write_word(ADR_D, 32'h1357_9bdf, 4'b1100);
    read_word(ADR_D, 1'b1);
    // Set 3 LRU: B replaces nothing, A touched, C evicts B
    read_word(ADR_B, 1'b1);
    read_word(ADR_A, 1'b0);
    read_word(ADR_C, 1'b1);
    read_word(ADR_A, 1'b0);
    read_word(ADR_B, 1'b1);
    // Invalidate set 3
    spr_write(SPR_DCBIR_ADDR, ADR_A);
    read_word(ADR_A, 1'b1);
    spr_write(16'h0001, 32'hffff_ffff);
    read_word(ADR_A, 1'b0);
    // Flush set 5
    read_word(ADR_D, 1'b0);
    spr_write(SPR_DCBFR_ADDR, ADR_D);
    read_word(ADR_D, 1'b1);

    repeat (4) @(posedge clk);
    total = data_errs + proto_errs + UUT.u_sva.fail_cnt;
    $display("errors: %0d data, %0d protocol, %0d bound", data_errs, proto_errs,
             UUT.u_sva.fail_cnt);
    if (total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
